// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    localparam int xlen = 32;
    localparam int line_bits = 128;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

    localparam int ic_lines = 16;
    localparam int ic_offset_bits = $clog2(line_bits / 8);
    localparam int ic_index_bits = $clog2(ic_lines);
    localparam int ic_tag_bits = xlen - ic_index_bits - ic_offset_bits;

    localparam int btb_entries = 16;
    localparam int btb_index_bits = $clog2(btb_entries);
    localparam int btb_tag_bits = xlen - btb_index_bits - 2;

    localparam logic [6:0] opc_branch = 7'b110_0011;
    localparam logic [6:0] opc_jal = 7'b110_1111;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic            compressed;
        logic            pred_taken;
    } fetch_out_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
    } bp_update_t;

    typedef struct packed {
        logic [xlen-1:0] addr; // line aligned
    } mem_req_t;

    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_word_u;

    typedef enum logic [1:0] {
        kind_other,
        kind_branch,
        kind_jal
    } instr_kind_e;

endpackage

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            stall_i,
    input  redirect_t       redirect_i,
    input  logic            pred_taken_i,
    input  logic [xlen-1:0] pred_target_i,
    output logic [xlen-1:0] pc_o
);

    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] redirect_word;
    logic [xlen-1:0] pred_word;
    logic [xlen-1:0] step_word;

    // an odd halfword target is fetched from its enclosing word, the queue drops the low half
    assign redirect_word = {redirect_i.target[xlen-1:2], 2'b00};
    assign pred_word = {pred_target_i[xlen-1:2], 2'b00};
    assign step_word = pc_q + 32'd4;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= reset_pc;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_word; // execute and decode override any prediction
        end else if (pred_taken_i) begin
            pc_q <= pred_word;
        end else if (!stall_i) begin
            pc_q <= step_word;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [xlen-1:0]      addr_i,
    input  logic                 flush_i,
    output logic [xlen-1:0]      word_o,
    output logic                 word_valid_o,
    output logic [xlen-1:0]      word_pc_o,
    output logic                 mem_req_valid_o,
    output mem_req_t             mem_req_o,
    input  logic                 mem_req_ready_i,
    input  logic                 mem_resp_valid_i,
    input  logic [line_bits-1:0] mem_resp_line_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } ic_state_e;

    ic_state_e state_q;

    logic [ic_tag_bits-1:0]    tag_q [ic_lines];
    logic [line_bits-1:0]      data_q [ic_lines];
    logic [ic_lines-1:0]       line_valid_q;

    logic [ic_index_bits-1:0]  idx;
    logic [ic_tag_bits-1:0]    tag;
    logic [1:0]                sel;
    logic                      hit;

    logic [xlen-1:0]           miss_addr_q;
    logic [ic_index_bits-1:0]  miss_idx;
    logic                      drop_q;
    logic                      refill;

    assign idx = addr_i[ic_offset_bits +: ic_index_bits];
    assign tag = addr_i[xlen-1 -: ic_tag_bits];
    assign sel = addr_i[ic_offset_bits-1:2];
    assign hit = (state_q == st_idle) && line_valid_q[idx] && (tag_q[idx] == tag);

    assign miss_idx = miss_addr_q[ic_offset_bits +: ic_index_bits];
    assign refill = (state_q == st_wait) && mem_resp_valid_i;

    assign mem_req_valid_o = (state_q == st_req);
    assign mem_req_o.addr = {miss_addr_q[xlen-1:ic_offset_bits], {ic_offset_bits{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= st_idle;
            line_valid_q <= '0;
            word_valid_o <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (hit) begin
                        word_valid_o <= 1'b1;
                    end else begin
                        state_q <= st_req;
                        drop_q <= flush_i;
                    end
                end
                st_req: begin
                    drop_q <= drop_q | flush_i;
                    if (mem_req_ready_i) begin
                        state_q <= st_wait;
                    end
                end
                default: begin
                    drop_q <= drop_q | flush_i;
                    if (mem_resp_valid_i) begin
                        state_q <= st_idle;
                        line_valid_q[miss_idx] <= 1'b1;
                        word_valid_o <= !(drop_q | flush_i); // line is kept even when flushed
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == st_idle && !hit) begin
            miss_addr_q <= addr_i;
        end
        if (refill) begin
            tag_q[miss_idx] <= miss_addr_q[xlen-1 -: ic_tag_bits];
            data_q[miss_idx] <= mem_resp_line_i;
            word_o <= mem_resp_line_i[miss_addr_q[ic_offset_bits-1:2]*xlen +: xlen];
            word_pc_o <= miss_addr_q;
        end else if (hit) begin
            word_o <= data_q[idx][sel*xlen +: xlen];
            word_pc_o <= addr_i;
        end
    end

endmodule

// ==== hdl/instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [xlen-1:0] word_i,
    input  logic [xlen-1:0] word_pc_i,
    input  logic            word_valid_i,
    input  logic            flush_i,
    input  logic            skip_half_i,
    input  logic            pop_i,
    output logic [xlen-1:0] head_instr_o,
    output logic [xlen-1:0] head_pc_o,
    output logic            head_valid_o,
    output logic            head_compressed_o,
    output logic            full_o
);

    logic [15:0]     hw_q [4];
    logic [15:0]     hw_d [4];
    logic [2:0]      count_q;
    logic [2:0]      count_d;
    logic [2:0]      pop_n;
    logic [2:0]      kept;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_d;
    logic            skip_q; // first word after a flush starts at its upper half
    logic            accept;

    assign head_compressed_o = (hw_q[0][1:0] != 2'b11);
    assign head_valid_o = (count_q >= 3'd2) || (count_q == 3'd1 && head_compressed_o);
    assign head_instr_o = head_compressed_o ? {16'h0000, hw_q[0]} : {hw_q[1], hw_q[0]};
    assign head_pc_o = pc_q;

    assign full_o = (count_q > 3'd2); // a whole word must fit
    assign accept = word_valid_i && !full_o;
    assign pop_n = !pop_i ? 3'd0 : (head_compressed_o ? 3'd1 : 3'd2);
    assign kept = count_q - pop_n;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hw_d[i] = hw_q[(i + int'(pop_n)) % 4]; // slots past kept are don't care
            if (accept && i == int'(kept)) begin
                hw_d[i] = skip_q ? word_i[31:16] : word_i[15:0];
            end
            if (accept && !skip_q && i == int'(kept) + 1) begin
                hw_d[i] = word_i[31:16];
            end
        end
        count_d = kept;
        if (accept) begin
            count_d = kept + (skip_q ? 3'd1 : 3'd2);
        end
        pc_d = pc_q + {{(xlen-4){1'b0}}, pop_n, 1'b0};
        if (accept && kept == 3'd0) begin
            pc_d = word_pc_i + {{(xlen-2){1'b0}}, skip_q, 1'b0};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= 3'd0;
            skip_q <= 1'b0;
        end else if (flush_i) begin
            count_q <= 3'd0;
            skip_q <= skip_half_i;
        end else begin
            count_q <= count_d;
            if (accept) begin
                skip_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        hw_q <= hw_d;
        pc_q <= pc_d;
    end

endmodule

// ==== hdl/predecoder.sv ====
`timescale 1ns/1ps

module predecoder import fetch_pkg::*; (
    input  logic [xlen-1:0] instr_i,
    input  logic            valid_i,
    output instr_kind_e     kind_o,
    output logic [xlen-1:0] imm_o
);

    instr_word_u w;
    logic        full_len;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;

    assign w = instr_i;
    assign full_len = (instr_i[1:0] == 2'b11); // compressed forms are left to decode

    assign b_imm = {{19{w.b_fmt.imm12}}, w.b_fmt.imm12, w.b_fmt.imm11,
                    w.b_fmt.imm10_5, w.b_fmt.imm4_1, 1'b0};
    assign j_imm = {{11{w.j_fmt.imm20}}, w.j_fmt.imm20, w.j_fmt.imm19_12,
                    w.j_fmt.imm11, w.j_fmt.imm10_1, 1'b0};

    always_comb begin
        kind_o = kind_other;
        imm_o = '0;
        if (valid_i && full_len) begin
            if (w.b_fmt.opcode == opc_branch) begin
                kind_o = kind_branch;
                imm_o = b_imm;
            end else if (w.j_fmt.opcode == opc_jal) begin
                kind_o = kind_jal;
                imm_o = j_imm;
            end
        end
    end

endmodule

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [xlen-1:0] lookup_pc_i,
    input  logic            lookup_en_i,
    input  bp_update_t      update_i,
    output logic            pred_taken_o,
    output logic [xlen-1:0] pred_target_o
);

    logic [btb_entries-1:0]  entry_valid_q;
    logic [1:0]              ctr_q [btb_entries];
    logic [btb_tag_bits-1:0] tag_q [btb_entries];
    logic [xlen-1:0]         target_q [btb_entries];

    logic [btb_index_bits-1:0] l_idx;
    logic [btb_tag_bits-1:0]   l_tag;
    logic [btb_index_bits-1:0] u_idx;
    logic [btb_tag_bits-1:0]   u_tag;
    logic                      u_hit;
    logic [1:0]                u_ctr;
    logic [1:0]                u_ctr_next;

    assign l_idx = lookup_pc_i[btb_index_bits+1:2];
    assign l_tag = lookup_pc_i[xlen-1 -: btb_tag_bits];
    assign u_idx = update_i.pc[btb_index_bits+1:2];
    assign u_tag = update_i.pc[xlen-1 -: btb_tag_bits];

    assign pred_taken_o = lookup_en_i && entry_valid_q[l_idx] && (tag_q[l_idx] == l_tag)
                          && ctr_q[l_idx][1];
    assign pred_target_o = target_q[l_idx];

    // a newly allocated entry starts from weakly not-taken
    assign u_hit = entry_valid_q[u_idx] && (tag_q[u_idx] == u_tag);
    assign u_ctr = u_hit ? ctr_q[u_idx] : 2'b01;

    always_comb begin
        u_ctr_next = u_ctr;
        if (update_i.taken && u_ctr != 2'b11) begin
            u_ctr_next = u_ctr + 2'd1;
        end else if (!update_i.taken && u_ctr != 2'b00) begin
            u_ctr_next = u_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            entry_valid_q <= '0;
            for (int i = 0; i < btb_entries; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (update_i.valid) begin
            entry_valid_q[u_idx] <= 1'b1;
            ctr_q[u_idx] <= u_ctr_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            tag_q[u_idx] <= u_tag;
            if (update_i.taken) begin
                target_q[u_idx] <= update_i.target; // not-taken keeps the last known target
            end
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    output logic                 mem_req_valid_o,
    output mem_req_t             mem_req_o,
    input  logic                 mem_req_ready_i,
    input  logic                 mem_resp_valid_i,
    input  logic [line_bits-1:0] mem_resp_line_i,
    output logic                 fetch_valid_o,
    output fetch_out_t           fetch_o,
    input  logic                 decode_ready_i,
    input  redirect_t            redirect_i,
    input  bp_update_t           bp_update_i
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] word;
    logic [xlen-1:0] word_pc;
    logic            word_valid;
    logic            word_take;
    logic            stall;
    logic            flush;
    logic            skip_half;

    logic [xlen-1:0] head_instr;
    logic [xlen-1:0] head_pc;
    logic            head_valid;
    logic            head_compressed;
    logic            queue_full;
    logic            pop;

    instr_kind_e     kind;
    logic [xlen-1:0] imm;
    logic            bp_taken;
    logic [xlen-1:0] bp_target;
    logic            pred_hit;
    logic            pred_fire;

    fetch_out_t      out_q;
    logic            out_valid_q;
    logic            out_load;

    // the cache replays the held pc, only the word for the current pc counts
    assign word_take = word_valid && (word_pc == pc);
    assign stall = !word_take || queue_full;

    assign out_load = !out_valid_q || decode_ready_i;
    assign pop = head_valid && out_load && !redirect_i.valid;

    // a btb entry is trusted only if it agrees with the offset in the word itself
    assign pred_hit = bp_taken && (bp_target == head_pc + imm);
    assign pred_fire = pop && pred_hit;
    assign flush = redirect_i.valid || pred_fire;
    assign skip_half = redirect_i.valid ? redirect_i.target[1] : bp_target[1];

    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .redirect_i    (redirect_i),
        .pred_taken_i  (pred_fire),
        .pred_target_i (bp_target),
        .pc_o          (pc)
    );

    icache_ctrl u_icache_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .addr_i           (pc),
        .flush_i          (flush),
        .word_o           (word),
        .word_valid_o     (word_valid),
        .word_pc_o        (word_pc),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_line_i  (mem_resp_line_i)
    );

    instr_queue u_instr_queue (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .word_i            (word),
        .word_pc_i         (word_pc),
        .word_valid_i      (word_take),
        .flush_i           (flush),
        .skip_half_i       (skip_half),
        .pop_i             (pop),
        .head_instr_o      (head_instr),
        .head_pc_o         (head_pc),
        .head_valid_o      (head_valid),
        .head_compressed_o (head_compressed),
        .full_o            (queue_full)
    );

    predecoder u_predecoder (
        .instr_i (head_instr),
        .valid_i (head_valid),
        .kind_o  (kind),
        .imm_o   (imm)
    );

    branch_predictor u_branch_predictor (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_pc_i   (head_pc),
        .lookup_en_i   (kind == kind_branch),
        .update_i      (bp_update_i),
        .pred_taken_o  (bp_taken),
        .pred_target_o (bp_target)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (redirect_i.valid) begin
            out_valid_q <= 1'b0;
        end else if (out_load) begin
            out_valid_q <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (redirect_i.valid) begin
            out_q.instr <= nop_instr;
            out_q.pred_taken <= 1'b0;
        end else if (pop) begin
            out_q.pc <= head_pc;
            out_q.instr <= head_instr;
            out_q.compressed <= head_compressed;
            out_q.pred_taken <= pred_hit;
        end
    end

    assign fetch_valid_o = out_valid_q;
    assign fetch_o = out_q;

endmodule

// ==== test/fetch_mem_model.sv ====
`timescale 1ns/1ps

module fetch_mem_model import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_valid_i,
    input  mem_req_t             req_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output logic [line_bits-1:0] resp_line_o
);

    localparam int mem_halves = 1024; // 2 KiB of program space
    localparam int mem_lines = mem_halves / 8;
    localparam int max_delay = 8;

    logic [15:0]     mem [mem_halves];
    int              line_reqs [mem_lines]; // refill requests per line since reset
    integer          seed = 32'h60d9_339b;
    logic            busy;
    logic [xlen-1:0] addr_q;
    int              wait_q;
    int              delay;

    task automatic put_half(input logic [xlen-1:0] addr, input logic [15:0] data);
        mem[addr[10:1]] = data;
    endtask

    function automatic logic [line_bits-1:0] read_line(input logic [xlen-1:0] addr);
        logic [line_bits-1:0] line;
        for (int i = 0; i < 8; i++) begin
            line[16*i +: 16] = mem[{addr[10:4], 3'(i)}]; // lowest halfword first
        end
        return line;
    endfunction

    assign req_ready_o = !busy;

    always @(posedge clk_i) begin
        resp_valid_o <= 1'b0;
        if (rst_i) begin
            busy <= 1'b0;
            for (int i = 0; i < mem_lines; i++) begin
                line_reqs[i] <= 0;
            end
        end else if (busy) begin
            wait_q <= wait_q - 1;
            if (wait_q == 1) begin
                busy <= 1'b0;
                resp_valid_o <= 1'b1;
                resp_line_o <= read_line(addr_q);
            end
        end else if (req_valid_i) begin
            delay = 1 + int'($unsigned($random(seed)) % max_delay);
            busy <= 1'b1;
            addr_q <= req_i.addr;
            wait_q <= delay;
            line_reqs[req_i.addr[10:4]] <= line_reqs[req_i.addr[10:4]] + 1;
        end
    end

endmodule

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int clk_period = 100;
    localparam int mem_bytes = 2048;
    localparam int max_mem_delay = 8; // same bound as the memory model
    localparam int cycles_per_instr = 4 * (max_mem_delay + 4);
    localparam int total_instr = 24 + 14 + 18 + 16 + 24 + 28; // sum over all tests
    localparam int setup_cycles = 6 * 40; // resets, redirects and training
    localparam int watchdog_ns = (total_instr * cycles_per_instr + setup_cycles) * clk_period;
    localparam logic [31:0] no_branch = 32'hffff_fffc;

    logic                 clk;
    logic                 rst;
    logic                 mem_req_valid;
    mem_req_t             mem_req;
    logic                 mem_req_ready;
    logic                 mem_resp_valid;
    logic [line_bits-1:0] mem_resp_line;
    logic                 fetch_valid;
    fetch_out_t           fetch;
    logic                 decode_ready;
    redirect_t            redirect;
    bp_update_t           bp_update;

    logic [15:0] img [mem_bytes/2]; // expected program image, halfword granular
    fetch_out_t  got[$];
    fetch_out_t  exp[$];
    fetch_out_t  held;
    logic        hold_q;
    logic        check_hold;
    int          hold_errs;
    int          req_errs;
    int          passed;
    int          failed;
    integer      seed = 32'h60d9_339b;
    logic [31:0] emit_pc;

    fetch_stage DUT (
        .clk_i            (clk),
        .rst_i            (rst),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .mem_req_ready_i  (mem_req_ready),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_line_i  (mem_resp_line),
        .fetch_valid_o    (fetch_valid),
        .fetch_o          (fetch),
        .decode_ready_i   (decode_ready),
        .redirect_i       (redirect),
        .bp_update_i      (bp_update)
    );

    fetch_mem_model u_mem (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_valid_i  (mem_req_valid),
        .req_i        (mem_req),
        .req_ready_o  (mem_req_ready),
        .resp_valid_o (mem_resp_valid),
        .resp_line_o  (mem_resp_line)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t ns, the run did not finish in time", $time);
        $display("TEST FAILED");
        $finish;
    end

    // transfers and hold checks are sampled at the rising edge
    always @(posedge clk) begin
        if (!rst && fetch_valid && decode_ready) begin
            got.push_back(fetch);
        end
        if (!rst && mem_req_valid && mem_req_ready && mem_req.addr[3:0] != 4'h0) begin
            $display("** Error at %0t: memory request address %h is not line aligned",
                     $time, mem_req.addr);
            req_errs++;
        end
        if (check_hold && hold_q && (!fetch_valid || fetch !== held)) begin
            $display("** Error at %0t: fetch_o changed while stalled, was %h now %h",
                     $time, held, fetch);
            hold_errs++;
        end
        hold_q = (fetch_valid === 1'b1) && !decode_ready;
        held = fetch;
    end

    task automatic store_half(input logic [31:0] addr, input logic [15:0] data);
        img[addr[10:1]] = data;
        u_mem.put_half(addr, data);
    endtask

    task automatic emit_c(input logic [15:0] hw);
        store_half(emit_pc, hw);
        emit_pc = emit_pc + 32'd2;
    endtask

    task automatic emit_w(input logic [31:0] w);
        store_half(emit_pc, w[15:0]);
        store_half(emit_pc + 32'd2, w[31:16]);
        emit_pc = emit_pc + 32'd4;
    endtask

    // every word is addi x1, x0, imm with imm taken from its own address
    task automatic fill_mem();
        logic [31:0] w;
        for (int a = 0; a < mem_bytes; a += 4) begin
            w = {a[11:0], 5'd0, 3'b000, 5'd1, 7'b001_0011};
            store_half(a, w[15:0]);
            store_half(a + 2, w[31:16]);
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        got.delete();
    endtask

    task automatic redirect_to(input logic [31:0] target);
        @(negedge clk);
        redirect.valid = 1'b1;
        redirect.target = target;
        @(negedge clk);
        redirect.valid = 1'b0;
        got.delete(); // a transfer in the redirect cycle still belongs to the old path
    endtask

    task automatic train_branch(input logic [31:0] pc, input logic [31:0] target,
                                input logic taken);
        @(negedge clk);
        bp_update.valid = 1'b1;
        bp_update.taken = taken;
        bp_update.pc = pc;
        bp_update.target = target;
        @(negedge clk);
        bp_update.valid = 1'b0;
    endtask

    task automatic collect(input int n, input bit random_ready);
        int cycles;
        cycles = 0;
        while (got.size() < n && cycles < n * cycles_per_instr) begin
            @(negedge clk);
            if (random_ready) begin
                decode_ready = 1'($random(seed));
            end
            cycles++;
        end
        decode_ready = 1'b1;
    endtask

    // walks the image from start, 2 bytes for compressed and 4 otherwise
    task automatic build_ref(input logic [31:0] start, input int n,
                             input logic [31:0] br_pc, input logic [31:0] br_target);
        logic [31:0] pc;
        logic [15:0] lo;
        fetch_out_t  e;
        pc = start;
        exp.delete();
        for (int i = 0; i < n; i++) begin
            lo = img[pc[10:1]];
            e.pc = pc;
            e.compressed = (lo[1:0] != 2'b11);
            e.instr = e.compressed ? {16'h0000, lo} : {img[pc[10:1] + 10'd1], lo};
            e.pred_taken = (pc == br_pc);
            exp.push_back(e);
            if (e.pred_taken) begin
                pc = br_target;
            end else begin
                pc = pc + (e.compressed ? 32'd2 : 32'd4);
            end
        end
    endtask

    function automatic int check_list();
        int errs;
        errs = 0;
        if (got.size() < exp.size()) begin
            $display("only %0d of %0d expected instructions arrived before the timeout",
                     got.size(), exp.size());
            errs++;
        end
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            if (got[i] !== exp[i]) begin
                $display("** Error at %0t: item %0d pc %h instr %h c %b p %b, expected %h %h %b %b",
                         $time, i, got[i].pc, got[i].instr, got[i].compressed,
                         got[i].pred_taken, exp[i].pc, exp[i].instr, exp[i].compressed,
                         exp[i].pred_taken);
                errs++;
            end
        end
        return errs;
    endfunction

    function automatic int check_reuse();
        int         errs;
        logic [6:0] line;
        errs = 0;
        foreach (exp[i]) begin
            line = exp[i].pc[10:4];
            if (u_mem.line_reqs[line] != 1) begin
                $display("** Error at %0t: line %h was requested %0d times", $time,
                         {line, 4'h0}, u_mem.line_reqs[line]);
                errs++;
            end
        end
        return errs;
    endfunction

    task automatic close_test(input string name, input int errs);
        int total;
        total = errs + req_errs;
        req_errs = 0;
        if (total == 0) begin
            passed++;
            $display("%-14s passed", name);
        end else begin
            failed++;
            $display("%-14s failed with %0d errors", name, total);
        end
    endtask

    task automatic test_sequential();
        fill_mem();
        reset_dut();
        collect(24, 1'b0);
        build_ref(reset_pc, 24, no_branch, '0);
        close_test("sequential", check_list());
    endtask

    task automatic test_compressed();
        fill_mem();
        emit_pc = reset_pc;
        emit_c(16'h0001);
        emit_w(32'h0010_0093);
        emit_c(16'h4085);
        emit_w(32'h0020_0113);
        emit_c(16'h4109);
        emit_w(32'h0030_0193); // crosses the line boundary at 0x10
        emit_c(16'h0001);
        emit_w(32'h0040_0213);
        reset_dut();
        collect(14, 1'b0);
        build_ref(reset_pc, 14, no_branch, '0);
        close_test("compressed", check_list());
    endtask

    task automatic test_redirect();
        int errs;
        fill_mem();
        emit_pc = 32'h0000_0206;
        emit_w(32'h0050_0293);
        emit_c(16'h4085);
        reset_dut();
        collect(4, 1'b0);
        build_ref(reset_pc, 4, no_branch, '0);
        errs = check_list();
        redirect_to(32'h0000_0100);
        collect(6, 1'b0);
        build_ref(32'h0000_0100, 6, no_branch, '0);
        errs += check_list();
        redirect_to(32'h0000_0206); // odd halfword target
        collect(8, 1'b0);
        build_ref(32'h0000_0206, 8, no_branch, '0);
        errs += check_list();
        close_test("redirect", errs);
    endtask

    task automatic test_prediction();
        int errs;
        int ctr;
        fill_mem();
        emit_pc = 32'h0000_0400;
        emit_w(32'h0400_0063); // beq x0, x0, +64
        reset_dut();
        ctr = 1;
        errs = 0;
        repeat (2) begin
            train_branch(32'h0000_0400, 32'h0000_0440, 1'b1);
            ctr = (ctr < 3) ? ctr + 1 : 3;
        end
        redirect_to(32'h0000_03f0);
        collect(8, 1'b0);
        build_ref(32'h0000_03f0, 8, (ctr >= 2) ? 32'h0000_0400 : no_branch, 32'h0000_0440);
        errs += check_list();
        repeat (2) begin
            train_branch(32'h0000_0400, 32'h0000_0440, 1'b0);
            ctr = (ctr > 0) ? ctr - 1 : 0;
        end
        redirect_to(32'h0000_03f0);
        collect(8, 1'b0);
        build_ref(32'h0000_03f0, 8, (ctr >= 2) ? 32'h0000_0400 : no_branch, 32'h0000_0440);
        errs += check_list();
        close_test("prediction", errs);
    endtask

    task automatic test_backpressure();
        fill_mem();
        reset_dut();
        hold_errs = 0;
        check_hold = 1'b1;
        collect(24, 1'b1);
        check_hold = 1'b0;
        build_ref(reset_pc, 24, no_branch, '0);
        close_test("backpressure", check_list() + hold_errs);
    endtask

    task automatic test_cache_reuse();
        int errs;
        fill_mem();
        reset_dut();
        collect(12, 1'b0);
        build_ref(reset_pc, 12, no_branch, '0);
        errs = check_list();
        repeat (2) begin
            redirect_to(reset_pc); // loop back over code already cached
            collect(8, 1'b0);
            build_ref(reset_pc, 8, no_branch, '0);
            errs += check_list();
            errs += check_reuse();
        end
        close_test("cache reuse", errs);
    endtask

    initial begin
        rst = 1'b1;
        decode_ready = 1'b1;
        redirect = '0;
        bp_update = '0;
        check_hold = 1'b0;
        hold_q = 1'b0;
        hold_errs = 0;
        req_errs = 0;
        passed = 0;
        failed = 0;
        test_sequential();
        test_compressed();
        test_redirect();
        test_prediction();
        test_backpressure();
        test_cache_reuse();
        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/icache_ctrl.sv
hdl/instr_queue.sv
hdl/predecoder.sv
hdl/branch_predictor.sv
hdl/fetch_stage.sv
test/fetch_mem_model.sv
test/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST OK
FAIL_MSG  ?= TEST FAILED

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
